// ==== src.f ====
+incdir+tb
logic/pio_pkg.sv
logic/pio_decoder.sv
logic/pio_osr.sv
logic/pio_tx_fifo.sv
logic/pio_wb_regs.sv
logic/pio_sm.sv
logic/pio_top.sv
tb/pio_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := pio_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/pio_tb_model.svh ====
//////////////////////////////////////////////////
// Reference model for the PIO testbench
// Needs pio_pkg imported by the including module
//////////////////////////////////////////////////
`ifndef PIO_TB_MODEL_SVH
`define PIO_TB_MODEL_SVH

  // FSTAT as the register map lays it out
  function automatic word_t expected_fstat(int level);
    word_t w;
    w = '0;
    w[FSTAT_LEVEL_LSB +: FIFO_LEVEL_W] = FIFO_LEVEL_W'(level);
    w[FSTAT_FULL_BIT]  = (level == FIFO_DEPTH);
    w[FSTAT_EMPTY_BIT] = (level == 0);
    return w;
  endfunction

  function automatic word_t bit_reverse(word_t w);
    word_t r;
    for (int i = 0; i < 32; i++) begin
      r[i] = w[31 - i];
    end
    return r;
  endfunction

  // Bit i of val goes to pin (base + i) mod 32, others keep old
  function automatic word_t place_bits(word_t old, word_t val, int base, int count);
    word_t res;
    res = old;
    for (int i = 0; i < count; i++) begin
      res[(base + i) % 32] = val[i];
    end
    return res;
  endfunction

  // Byte number idx of a word as a run of OUT 8 sends it
  function automatic logic [7:0] out_byte(word_t w, int idx, logic shift_right);
    if (shift_right) return w[8*idx +: 8]; // Least significant byte first
    return w[31 - 8*idx -: 8];
  endfunction

  function automatic int loop_passes(int x_init);
    return x_init + 1; // JMP X-- jumps x_init times
  endfunction

  function automatic pc_t next_pc(pc_t cur, pc_t bottom, pc_t top);
    if (cur == top) return bottom;
    return cur + 1'b1;
  endfunction

`endif

// ==== tb/pio_tb.sv ====
//////////////////////////////////////////////////
// Testbench for pio_top, ROM answers pc combinationally
// Stops at the first error, run limit 4000 cycles
//////////////////////////////////////////////////
`timescale 1ns/100ps
module pio_tb;
  import pio_pkg::*;

  `include "pio_tb_model.svh"

  localparam int TIMEOUT_CYCLES = 4000; // About 4x the longest sequence
  localparam int SETTLE_CYCLES  = 8;

  logic             clk;
  logic             reset;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  word_t            wb_dat_w;
  word_t            wb_dat_r;
  logic             wb_ack;
  instr_t           instr;
  pc_t              pc;
  word_t            output_pins;
  word_t            pin_directions;

  instr_t rom [32];
  word_t  words [FIFO_DEPTH];
  word_t  exp_pins [$];
  word_t  last_pins = '0;
  integer seed = 10;
  int     cycles = 0;
  int     pin_changes = 0;
  logic   watch_pins = 1'b1;
  logic   watch_pc = 1'b0;
  pc_t    pc_limit = '0;

  pio_top dut_i (
    .clk            (clk),
    .reset          (reset),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .instr          (instr),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .pc             (pc),
    .output_pins    (output_pins),
    .pin_directions (pin_directions)
  );

  assign instr = rom[pc];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_fstat(input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED fstat: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_pc(input pc_t got, input pc_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED pc: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout, no progress after %0d cycles", cycles));
    end
  end

  // Pins and pc are sampled on the falling edge, away from the updates
  always @(negedge clk) begin
    if (!reset) begin
      if (watch_pc && pc > pc_limit) begin
        fail_run($sformatf("pc 0x%h left the wrap window", pc));
      end
      if (output_pins !== last_pins) begin
        pin_changes++;
        if (watch_pins && exp_pins.size() == 0) begin
          fail_run($sformatf("output_pins changed to 0x%h with no change expected",
                             output_pins));
        end else if (watch_pins) begin
          check_word("output_pins", output_pins, exp_pins.pop_front());
        end
      end
    end
    last_pins = output_pins;
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (16) step();
    reset = 1'b0;
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] adr, input word_t data, output int waited);
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    do begin
      step();
      waited++;
    end while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    step(); // Idle cycle between transfers
  endtask

  task automatic reg_write(input logic [ADR_W-1:0] adr, input word_t data);
    int waited;
    wb_write(adr, data, waited);
  endtask

  task automatic reg_read(input logic [ADR_W-1:0] adr, output word_t data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    do step(); while (!wb_ack);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    step();
  endtask

  function automatic instr_t encode(opcode_t op, logic [2:0] op1, logic [4:0] op2);
    return {op, 5'b00000, op1, op2}; // Bits 12:8 stay zero
  endfunction

  function automatic instr_t pull_instr(logic block);
    return encode(OP_PUSHPULL, {1'b1, 1'b0, block}, 5'd0);
  endfunction

  function automatic instr_t mov_instr(logic [2:0] dest, logic [1:0] mop, logic [2:0] src);
    return encode(OP_MOV, dest, {mop, src});
  endfunction

  function automatic word_t ctrl_word(logic sr, logic ap);
    word_t w;
    w = '0;
    w[CTRL_ENABLE_BIT]      = 1'b1;
    w[CTRL_SHIFT_RIGHT_BIT] = sr;
    w[CTRL_AUTOPULL_BIT]    = ap; // Threshold field 0 means 32
    return w;
  endfunction

  function automatic word_t pinctrl_word(int out_base, int out_count, int set_count);
    word_t w;
    w = '0;
    w[PINCTRL_OUT_BASE_LSB +: 5]  = 5'(out_base);
    w[PINCTRL_OUT_COUNT_LSB +: 6] = 6'(out_count);
    w[PINCTRL_SET_COUNT_LSB +: 3] = 3'(set_count);
    return w;
  endfunction

  function automatic word_t wrap_word(int bottom, int top);
    word_t w;
    w = '0;
    w[WRAP_BOTTOM_LSB +: 5] = 5'(bottom);
    w[WRAP_TOP_LSB +: 5]    = 5'(top);
    return w;
  endfunction

  task automatic clear_rom();
    for (int a = 0; a < 32; a++) begin
      rom[a] = encode(OP_JMP, 3'd0, 5'(a)); // Park on its own address
    end
  endtask

  // Neighbouring bytes differ, so every OUT shows up as a pin change
  task automatic make_words(input logic sr);
    word_t      w;
    logic [7:0] prev;
    logic       ok;
    prev = 8'h00;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      do begin
        w  = $random(seed);
        ok = (out_byte(w, 0, sr) != prev);
        for (int b = 1; b < 4; b++) begin
          if (out_byte(w, b, sr) == out_byte(w, b - 1, sr)) ok = 1'b0;
        end
      end while (!ok);
      words[i] = w;
      prev     = out_byte(w, 3, sr);
    end
  endtask

  task automatic wait_drained();
    while (exp_pins.size() != 0) step();
  endtask

  task automatic wait_pc(input pc_t target);
    while (pc != target) step();
  endtask

  task automatic after_reset_state();
    word_t rd;
    apply_reset();
    reg_read(REG_FSTAT, rd);
    check_fstat(rd, expected_fstat(0));
    check_word("output_pins", output_pins, '0);
    check_word("pin_directions", pin_directions, '0);
  endtask

  task automatic fifo_backpressure();
    word_t rd;
    int    waited;
    apply_reset();
    clear_rom();
    rom[0] = encode(OP_SET, SEL_X, 5'd31);
    rom[1] = encode(OP_JMP, 3'd2, 5'd1); // X-- delay before the pull
    rom[2] = pull_instr(1'b1);
    rom[3] = encode(OP_JMP, 3'd0, 5'd3);
    reg_write(REG_WRAP, wrap_word(0, 31));
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      rd = $random(seed);
      reg_write(REG_TXF, rd);
    end
    reg_read(REG_FSTAT, rd);
    check_fstat(rd, expected_fstat(FIFO_DEPTH));
    reg_write(REG_CTRL, ctrl_word(1'b0, 1'b0));
    rd = $random(seed);
    wb_write(REG_TXF, rd, waited);
    if (waited <= 31) begin
      fail_run("TXF write was acked while the FIFO was still full");
    end
    reg_read(REG_FSTAT, rd);
    check_fstat(rd, expected_fstat(FIFO_DEPTH));
  endtask

  task automatic serialize_bytes(input logic sr);
    word_t expect_pins;
    apply_reset();
    clear_rom();
    rom[0] = encode(OP_SET, SEL_PINDIRS, 5'd31);
    rom[1] = encode(OP_OUT, SEL_PINS, 5'd8);
    rom[2] = encode(OP_JMP, 3'd0, 5'd1);
    make_words(sr);
    expect_pins = '0;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      reg_write(REG_TXF, words[i]);
      for (int b = 0; b < 4; b++) begin
        expect_pins = place_bits(expect_pins, word_t'(out_byte(words[i], b, sr)), 0, 8);
        exp_pins.push_back(expect_pins);
      end
    end
    reg_write(REG_PINCTRL, pinctrl_word(0, 8, 5));
    reg_write(REG_WRAP, wrap_word(0, 31));
    reg_write(REG_CTRL, ctrl_word(sr, 1'b1));
    wait_drained();
    idle(SETTLE_CYCLES);
    check_word("pin_directions", pin_directions, place_bits('0, word_t'(31), 0, 5));
  endtask

  task automatic pull_and_mov(input logic [1:0] mop);
    word_t w;
    apply_reset();
    clear_rom();
    rom[0] = pull_instr(1'b1);
    rom[1] = mov_instr(SEL_X, mop, SEL_OSR);
    rom[2] = mov_instr(SEL_PINS, 2'd0, SEL_X);
    rom[3] = encode(OP_JMP, 3'd0, 5'd3);
    reg_write(REG_PINCTRL, pinctrl_word(0, 32, 0));
    reg_write(REG_WRAP, wrap_word(0, 31));
    reg_write(REG_CTRL, ctrl_word(1'b0, 1'b0));
    idle(SETTLE_CYCLES);
    check_pc(pc, '0); // Still blocked on the empty FIFO
    do w = $random(seed); while (w == '0 || w == '1);
    exp_pins.push_back((mop == MOV_INVERT) ? ~w : bit_reverse(w));
    reg_write(REG_TXF, w);
    wait_drained();
    idle(SETTLE_CYCLES);
  endtask

  task automatic jmp_countdown();
    int base;
    int passes;
    apply_reset();
    clear_rom();
    rom[0] = encode(OP_SET, SEL_X, 5'd5);
    rom[1] = encode(OP_SET, SEL_PINS, 5'd1);
    rom[2] = encode(OP_SET, SEL_PINS, 5'd0);
    rom[3] = encode(OP_JMP, 3'd2, 5'd1); // X-- back to the toggle
    rom[4] = encode(OP_JMP, 3'd0, 5'd4);
    passes = loop_passes(5);
    for (int i = 0; i < passes; i++) begin
      exp_pins.push_back(place_bits('0, word_t'(1), 0, 1));
      exp_pins.push_back('0);
    end
    base = pin_changes;
    reg_write(REG_PINCTRL, pinctrl_word(0, 0, 1));
    reg_write(REG_WRAP, wrap_word(0, 31));
    reg_write(REG_CTRL, ctrl_word(1'b0, 1'b0));
    wait_pc(5'd4);
    idle(SETTLE_CYCLES);
    check_word("pin toggles", word_t'((pin_changes - base) / 2), word_t'(passes));
  endtask

  task automatic wrap_window();
    word_t expect_pins;
    pc_t   model_pc;
    apply_reset();
    clear_rom();
    for (int a = 0; a < 3; a++) begin
      rom[a] = encode(OP_SET, SEL_PINS, 5'(a + 1)); // Pins show which slot ran
    end
    expect_pins = '0;
    model_pc    = '0;
    for (int k = 0; k < 20; k++) begin
      expect_pins = place_bits(expect_pins, word_t'(model_pc) + 1, 0, 2);
      exp_pins.push_back(expect_pins);
      model_pc = next_pc(model_pc, 5'd1, 5'd2);
    end
    pc_limit = 5'd2;
    watch_pc = 1'b1;
    reg_write(REG_PINCTRL, pinctrl_word(0, 0, 2));
    reg_write(REG_WRAP, wrap_word(1, 2));
    reg_write(REG_CTRL, ctrl_word(1'b0, 1'b0));
    wait_drained();
    watch_pins = 1'b0; // Machine keeps looping past the window
    idle(SETTLE_CYCLES);
    watch_pc = 1'b0;
  endtask

  initial begin
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    clear_rom();
    after_reset_state();
    fifo_backpressure();
    serialize_bytes(1'b1);
    serialize_bytes(1'b0);
    pull_and_mov(MOV_REVERSE);
    pull_and_mov(MOV_INVERT);
    jmp_countdown();
    wrap_window();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== logic/pio_top.sv ====
//////////////////////////////////////////////////
// PIO TX machine, program memory lives outside
// instr must follow pc in the same cycle
//////////////////////////////////////////////////
`timescale 1ns/100ps
module pio_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [pio_pkg::ADR_W-1:0]  wb_adr,
  input  pio_pkg::word_t             wb_dat_w,
  input  pio_pkg::instr_t            instr,
  output pio_pkg::word_t             wb_dat_r,
  output logic                       wb_ack,
  output pio_pkg::pc_t               pc,
  output pio_pkg::word_t             output_pins,
  output pio_pkg::word_t             pin_directions
);
  import pio_pkg::*;

  logic                    push;
  logic                    pop;
  logic                    fifo_full;
  logic                    fifo_empty;
  logic [FIFO_LEVEL_W-1:0] fifo_level;
  word_t                   push_data;
  word_t                   pop_data;
  logic                    enable;
  logic                    out_shift_right;
  logic                    autopull;
  count_t                  pull_thresh;
  count_t                  out_count;
  pin_idx_t                out_base;
  pin_idx_t                set_base;
  logic [2:0]              set_count;
  pc_t                     wrap_bottom;
  pc_t                     wrap_top;

  pio_wb_regs regs_i (
    .clk             (clk),
    .reset           (reset),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .fifo_full       (fifo_full),
    .fifo_empty      (fifo_empty),
    .fifo_level      (fifo_level),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .push            (push),
    .push_data       (push_data),
    .enable          (enable),
    .out_shift_right (out_shift_right),
    .autopull        (autopull),
    .pull_thresh     (pull_thresh),
    .out_base        (out_base),
    .out_count       (out_count),
    .set_base        (set_base),
    .set_count       (set_count),
    .wrap_bottom     (wrap_bottom),
    .wrap_top        (wrap_top)
  );

  pio_tx_fifo fifo_i (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (fifo_full),
    .empty     (fifo_empty),
    .level     (fifo_level)
  );

  pio_sm sm_i (
    .clk             (clk),
    .reset           (reset),
    .instr           (instr),
    .enable          (enable),
    .out_shift_right (out_shift_right),
    .autopull        (autopull),
    .pull_thresh     (pull_thresh),
    .out_base        (out_base),
    .set_base        (set_base),
    .out_count       (out_count),
    .set_count       (set_count),
    .wrap_bottom     (wrap_bottom),
    .wrap_top        (wrap_top),
    .fifo_empty      (fifo_empty),
    .fifo_data       (pop_data),
    .pc              (pc),
    .pop             (pop),
    .output_pins     (output_pins),
    .pin_directions  (pin_directions)
  );

endmodule

// ==== logic/pio_sm.sv ====
//////////////////////////////////////////////////
// One instruction per clock while enabled
// No side-set, delays, WAIT, IRQ or RX path
//////////////////////////////////////////////////
`timescale 1ns/100ps
module pio_sm (
  input  logic               clk,
  input  logic               reset,
  input  pio_pkg::instr_t    instr,
  input  logic               enable,
  input  logic               out_shift_right,
  input  logic               autopull,
  input  pio_pkg::count_t    pull_thresh,
  input  pio_pkg::pin_idx_t  out_base,
  input  pio_pkg::pin_idx_t  set_base,
  input  pio_pkg::count_t    out_count,
  input  logic [2:0]         set_count,
  input  pio_pkg::pc_t       wrap_bottom,
  input  pio_pkg::pc_t       wrap_top,
  input  logic               fifo_empty,
  input  pio_pkg::word_t     fifo_data,
  output pio_pkg::pc_t       pc,
  output logic               pop,
  output pio_pkg::word_t     output_pins,
  output pio_pkg::word_t     pin_directions
);
  import pio_pkg::*;

  opcode_t    op;
  logic [2:0] op1;
  pin_idx_t   op2;
  logic [2:0] mov_src;
  logic [1:0] mov_op;
  logic       is_pull;
  logic       blocking;

  word_t      x_q;
  word_t      y_q;
  word_t      x_next;
  word_t      y_next;
  word_t      osr_out;
  word_t      osr_load_data;
  word_t      mov_val;
  word_t      wr_val;
  count_t     osr_count;
  count_t     wr_count;
  pin_idx_t   wr_base;
  pin_idx_t   shift_bits;
  logic       osr_load;
  logic       osr_shift;
  logic       auto_due;
  logic       stall;
  logic       jump;
  logic       x_we;
  logic       y_we;
  logic       pins_we;
  logic       dirs_we;

  // Bit i of val lands on pin (base + i) mod 32
  function automatic word_t merge_pins(word_t old, word_t val, pin_idx_t base, count_t cnt);
    word_t    res;
    pin_idx_t idx;
    res = old;
    for (int i = 0; i < WORD_W; i++) begin
      idx = base + pin_idx_t'(i);
      if (i < cnt) res[idx] = val[i];
    end
    return res;
  endfunction

  pio_decoder decoder_i (
    .instr    (instr),
    .op       (op),
    .op1      (op1),
    .op2      (op2),
    .mov_src  (mov_src),
    .mov_op   (mov_op),
    .is_pull  (is_pull),
    .blocking (blocking)
  );

  // Outside OUT a 32-bit width makes shift_out the whole OSR for MOV
  assign shift_bits = (op == OP_OUT) ? op2 : '0;

  pio_osr osr_i (
    .clk         (clk),
    .reset       (reset),
    .load        (osr_load),
    .load_data   (osr_load_data),
    .shift       (osr_shift),
    .shift_bits  (shift_bits),
    .shift_right (out_shift_right),
    .shift_out   (osr_out),
    .count       (osr_count)
  );

  assign auto_due = autopull && (osr_count >= pull_thresh);

  always_comb begin
    case (mov_src)
      SEL_X:   mov_val = x_q;
      SEL_Y:   mov_val = y_q;
      SEL_OSR: mov_val = osr_out;
      default: mov_val = '0; // Null
    endcase
    case (mov_op)
      MOV_INVERT:  mov_val = ~mov_val;
      MOV_REVERSE: mov_val = {<<{mov_val}};
      default: ;
    endcase
  end

  always_comb begin
    stall         = 1'b0;
    jump          = 1'b0;
    pop           = 1'b0;
    osr_load      = 1'b0;
    osr_load_data = fifo_data;
    osr_shift     = 1'b0;
    x_we          = 1'b0;
    y_we          = 1'b0;
    x_next        = osr_out;
    y_next        = osr_out;
    pins_we       = 1'b0;
    dirs_we       = 1'b0;
    wr_val        = osr_out;
    wr_base       = out_base;
    wr_count      = out_count;
    if (enable) begin
      case (op)
        OP_JMP: begin
          case (op1)
            3'd0:    jump = 1'b1;
            3'd1:    jump = (x_q == '0);
            3'd2:    jump = (x_q != '0);
            3'd3:    jump = (y_q == '0);
            3'd4:    jump = (y_q != '0);
            3'd5:    jump = (x_q != y_q);
            3'd7:    jump = (osr_count < pull_thresh); // OSR not empty
            default: jump = 1'b0;                      // No pin condition
          endcase
          x_we   = (op1 == 3'd2) && (x_q != '0); // Post-decrement
          x_next = x_q - 1'b1;
          y_we   = (op1 == 3'd4) && (y_q != '0);
          y_next = y_q - 1'b1;
        end
        OP_OUT: begin
          if (auto_due) begin
            stall    = 1'b1; // Refill now, the OUT runs next cycle
            pop      = !fifo_empty;
            osr_load = !fifo_empty;
          end else begin
            osr_shift = 1'b1;
            pins_we   = (op1 == SEL_PINS);
            dirs_we   = (op1 == SEL_PINDIRS);
            x_we      = (op1 == SEL_X);
            y_we      = (op1 == SEL_Y);
          end
        end
        OP_PUSHPULL: begin
          if (is_pull) begin
            if (!fifo_empty) begin
              pop      = 1'b1;
              osr_load = 1'b1;
            end else if (blocking) begin
              stall = 1'b1;
            end else begin
              osr_load      = 1'b1; // Empty non-blocking pull takes X
              osr_load_data = x_q;
            end
          end
        end
        OP_MOV: begin
          wr_val        = mov_val;
          x_next        = mov_val;
          y_next        = mov_val;
          osr_load_data = mov_val;
          pins_we       = (op1 == SEL_PINS);
          x_we          = (op1 == SEL_X);
          y_we          = (op1 == SEL_Y);
          osr_load      = (op1 == SEL_OSR);
        end
        OP_SET: begin
          wr_val   = word_t'(op2);
          wr_base  = set_base;
          wr_count = count_t'(set_count);
          x_next   = word_t'(op2);
          y_next   = word_t'(op2);
          pins_we  = (op1 == SEL_PINS);
          dirs_we  = (op1 == SEL_PINDIRS);
          x_we     = (op1 == SEL_X);
          y_we     = (op1 == SEL_Y);
        end
        default: ; // WAIT, IN, IRQ and PUSH
      endcase
      if (op != OP_OUT && auto_due && !fifo_empty && !osr_load) begin
        pop      = 1'b1; // Background autopull
        osr_load = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc             <= '0;
      x_q            <= '0;
      y_q            <= '0;
      output_pins    <= '0;
      pin_directions <= '0;
    end else if (enable && !stall) begin
      if (jump) begin
        pc <= op2;
      end else if (pc == wrap_top) begin
        pc <= wrap_bottom;
      end else begin
        pc <= pc + 1'b1;
      end
      if (x_we) x_q <= x_next;
      if (y_we) y_q <= y_next;
      if (pins_we) output_pins <= merge_pins(output_pins, wr_val, wr_base, wr_count);
      if (dirs_we) pin_directions <= merge_pins(pin_directions, wr_val, wr_base, wr_count);
    end
  end

endmodule

// ==== logic/pio_wb_regs.sv ====
//////////////////////////////////////////////////
// Wishbone classic slave, acks one cycle after stb
// TXF writes hold off the ack while the FIFO is full
//////////////////////////////////////////////////
`timescale 1ns/100ps
module pio_wb_regs (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [pio_pkg::ADR_W-1:0]         wb_adr,
  input  pio_pkg::word_t                    wb_dat_w,
  input  logic                              fifo_full,
  input  logic                              fifo_empty,
  input  logic [pio_pkg::FIFO_LEVEL_W-1:0]  fifo_level,
  output pio_pkg::word_t                    wb_dat_r,
  output logic                              wb_ack,
  output logic                              push,
  output pio_pkg::word_t                    push_data,
  output logic                              enable,
  output logic                              out_shift_right,
  output logic                              autopull,
  output pio_pkg::count_t                   pull_thresh,
  output pio_pkg::pin_idx_t                 out_base,
  output pio_pkg::count_t                   out_count,
  output pio_pkg::pin_idx_t                 set_base,
  output logic [2:0]                        set_count,
  output pio_pkg::pc_t                      wrap_bottom,
  output pio_pkg::pc_t                      wrap_top
);
  import pio_pkg::*;

  word_t    ctrl_q;
  word_t    pinctrl_q;
  word_t    wrap_q;
  word_t    fstat;
  pin_idx_t thresh_field;
  logic     req;
  logic     txf_wr;

  assign req    = wb_cyc && wb_stb && !wb_ack; // Master still holds stb in the ack cycle
  assign txf_wr = req && wb_we && (wb_adr == REG_TXF);

  assign enable          = ctrl_q[CTRL_ENABLE_BIT];
  assign out_shift_right = ctrl_q[CTRL_SHIFT_RIGHT_BIT];
  assign autopull        = ctrl_q[CTRL_AUTOPULL_BIT];
  assign thresh_field    = ctrl_q[CTRL_THRESH_LSB +: $bits(pin_idx_t)];
  assign pull_thresh     = (thresh_field == '0) ? count_t'(WORD_W) : count_t'(thresh_field);
  assign out_base        = pinctrl_q[PINCTRL_OUT_BASE_LSB +: $bits(pin_idx_t)];
  assign out_count       = pinctrl_q[PINCTRL_OUT_COUNT_LSB +: $bits(count_t)];
  assign set_base        = pinctrl_q[PINCTRL_SET_BASE_LSB +: $bits(pin_idx_t)];
  assign set_count       = pinctrl_q[PINCTRL_SET_COUNT_LSB +: 3];
  assign wrap_bottom     = wrap_q[WRAP_BOTTOM_LSB +: $bits(pc_t)];
  assign wrap_top        = wrap_q[WRAP_TOP_LSB +: $bits(pc_t)];

  always_comb begin
    fstat = '0;
    fstat[FSTAT_LEVEL_LSB +: FIFO_LEVEL_W] = fifo_level;
    fstat[FSTAT_FULL_BIT]  = fifo_full;
    fstat[FSTAT_EMPTY_BIT] = fifo_empty;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack    <= 1'b0;
      push      <= 1'b0;
      ctrl_q    <= '0;
      pinctrl_q <= '0;
      wrap_q    <= '0;
    end else begin
      wb_ack <= req && !(txf_wr && fifo_full); // Back-pressure toward the host
      push   <= txf_wr && !fifo_full;          // Lands with the ack
      if (req && wb_we) begin
        case (wb_adr)
          REG_CTRL:    ctrl_q    <= wb_dat_w;
          REG_PINCTRL: pinctrl_q <= wb_dat_w;
          REG_WRAP:    wrap_q    <= wb_dat_w;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    push_data <= wb_dat_w;
    case (wb_adr)
      REG_CTRL:    wb_dat_r <= ctrl_q;
      REG_PINCTRL: wb_dat_r <= pinctrl_q;
      REG_WRAP:    wb_dat_r <= wrap_q;
      REG_FSTAT:   wb_dat_r <= fstat;
      default:     wb_dat_r <= '0; // TXF reads as zero
    endcase
  end

  // A pending cycle keeps its address and data until the ack
  a_hold_until_ack: assert property (@(posedge clk) disable iff (reset)
    req |=> (wb_ack || (wb_cyc && wb_stb && $stable({wb_we, wb_adr, wb_dat_w}))));
  a_push_not_full: assert property (@(posedge clk) disable iff (reset) !(push && fifo_full));

endmodule

// ==== logic/pio_tx_fifo.sv ====
//////////////////////////////////////////////////
// First-word-fall-through TX FIFO, no overflow guard
// Callers must respect full and empty
//////////////////////////////////////////////////
`timescale 1ns/100ps
module pio_tx_fifo (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              push,
  input  pio_pkg::word_t                    push_data,
  input  logic                              pop,
  output pio_pkg::word_t                    pop_data,
  output logic                              full,
  output logic                              empty,
  output logic [pio_pkg::FIFO_LEVEL_W-1:0]  level
);
  import pio_pkg::*;

  word_t                 mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;

  assign pop_data = mem[rd_ptr]; // Head word visible while not empty
  assign full     = (level == FIFO_LEVEL_W'(FIFO_DEPTH));
  assign empty    = (level == '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: ;
      endcase
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// ==== logic/pio_osr.sv ====
//////////////////////////////////////////////////
// Output shift register, shift of 0 bits means 32
//////////////////////////////////////////////////
`timescale 1ns/100ps
module pio_osr (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  pio_pkg::word_t     load_data,
  input  logic               shift,
  input  pio_pkg::pin_idx_t  shift_bits,
  input  logic               shift_right,
  output pio_pkg::word_t     shift_out,
  output pio_pkg::count_t    count
);
  import pio_pkg::*;

  word_t      osr_q;
  word_t      mask;
  count_t     n;
  logic [6:0] sum;

  assign n    = (shift_bits == '0) ? count_t'(WORD_W) : count_t'(shift_bits);
  assign mask = ~(word_t'('1) << n);
  assign sum  = count + n;

  // Selected bits come out right-aligned in both directions
  assign shift_out = shift_right ? (osr_q & mask) : (osr_q >> (count_t'(WORD_W) - n));

  always_ff @(posedge clk) begin
    if (load) begin
      osr_q <= load_data;
    end else if (shift) begin
      osr_q <= shift_right ? (osr_q >> n) : (osr_q << n); // Zero fill
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= count_t'(WORD_W); // Empty after reset
    end else if (load) begin
      count <= '0;
    end else if (shift) begin
      count <= (sum > 7'(WORD_W)) ? count_t'(WORD_W) : sum[5:0]; // Saturates at 32
    end
  end

  a_load_xor_shift: assert property (@(posedge clk) disable iff (reset) !(load && shift));

endmodule

// ==== logic/pio_decoder.sv ====
//////////////////////////////////////////////////
// Instruction field split, bits 12:8 are ignored
//////////////////////////////////////////////////
`timescale 1ns/100ps
module pio_decoder (
  input  pio_pkg::instr_t    instr,
  output pio_pkg::opcode_t   op,
  output logic [2:0]         op1,
  output pio_pkg::pin_idx_t  op2,
  output logic [2:0]         mov_src,
  output logic [1:0]         mov_op,
  output logic               is_pull,
  output logic               blocking
);
  import pio_pkg::*;

  assign op       = opcode_t'(instr[INSTR_OP_LSB +: 3]);
  assign op1      = instr[INSTR_OP1_LSB +: 3];   // Condition or destination
  assign op2      = instr[4:0];                  // Address, data or bit count
  assign mov_src  = instr[2:0];
  assign mov_op   = instr[INSTR_MOV_OP_LSB +: 2];
  assign is_pull  = instr[INSTR_PULL_BIT];       // Clear for PUSH
  assign blocking = instr[INSTR_BLOCK_BIT];

endmodule

// ==== logic/pio_pkg.sv ====
//////////////////////////////////////////////////
// Shared types, opcodes, instruction fields and register map
// FIFO_DEPTH must stay a power of two
//////////////////////////////////////////////////
package pio_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [15:0]       instr_t;
  typedef logic [4:0]        pc_t;
  typedef logic [5:0]        count_t;   // 0 to 32
  typedef logic [4:0]        pin_idx_t;

  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_WAIT     = 3'd1,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,
    OP_MOV      = 3'd5,
    OP_IRQ      = 3'd6,
    OP_SET      = 3'd7
  } opcode_t;

  // Instruction fields
  localparam int INSTR_OP_LSB     = 13;
  localparam int INSTR_OP1_LSB    = 5;
  localparam int INSTR_MOV_OP_LSB = 3;
  localparam int INSTR_PULL_BIT   = 7;
  localparam int INSTR_BLOCK_BIT  = 5;

  // Source and destination codes shared by OUT, SET and MOV
  localparam logic [2:0] SEL_PINS    = 3'd0;
  localparam logic [2:0] SEL_X       = 3'd1;
  localparam logic [2:0] SEL_Y       = 3'd2;
  localparam logic [2:0] SEL_NULL    = 3'd3;
  localparam logic [2:0] SEL_PINDIRS = 3'd4;
  localparam logic [2:0] SEL_OSR     = 3'd7;

  localparam logic [1:0] MOV_INVERT  = 2'd1;
  localparam logic [1:0] MOV_REVERSE = 2'd2;

  localparam int FIFO_DEPTH   = 4;
  localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
  localparam int FIFO_LEVEL_W = 3;

  // Register map, word addresses
  localparam int ADR_W = 3;
  localparam logic [ADR_W-1:0] REG_CTRL    = 3'd0;
  localparam logic [ADR_W-1:0] REG_PINCTRL = 3'd1;
  localparam logic [ADR_W-1:0] REG_WRAP    = 3'd2;
  localparam logic [ADR_W-1:0] REG_TXF     = 3'd3;
  localparam logic [ADR_W-1:0] REG_FSTAT   = 3'd4;

  localparam int CTRL_ENABLE_BIT       = 0;
  localparam int CTRL_SHIFT_RIGHT_BIT  = 1;
  localparam int CTRL_AUTOPULL_BIT     = 2;
  localparam int CTRL_THRESH_LSB       = 8;
  localparam int PINCTRL_OUT_BASE_LSB  = 0;
  localparam int PINCTRL_OUT_COUNT_LSB = 5;
  localparam int PINCTRL_SET_BASE_LSB  = 11;
  localparam int PINCTRL_SET_COUNT_LSB = 16;
  localparam int WRAP_BOTTOM_LSB       = 0;
  localparam int WRAP_TOP_LSB          = 8;
  localparam int FSTAT_LEVEL_LSB       = 0;
  localparam int FSTAT_FULL_BIT        = 8;
  localparam int FSTAT_EMPTY_BIT       = 9;

endpackage
